/* verilog/rp_macros.svh */
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// analog path dimensions
////////////////////////////////////////////////////////////////////////////

// number of ADC and DAC channels
`define RP_CHN 2

// stream sample, signed
`define RP_SAMPLE_W 14
// calibration gain, signed fixed point
`define RP_GAIN_W 16
`define RP_GAIN_FRAC 14
// gain of 1.0 in that format
`define RP_UNITY_GAIN 16384

// raw ADC pin bus, sample sits in the top bits
`define RP_PIN_W 16

// configuration port
`define RP_CFG_AW 4
`define RP_CFG_DW 16

// DAC mid-scale code driven out of reset
`define RP_DAC_RST_CODE 8192

`endif

/* verilog/rp_pkg.sv */
`include "rp_macros.svh"

package rp_pkg;

  //////////////////////////////////////////////////////////////////////////
  // data path types
  //////////////////////////////////////////////////////////////////////////

  // signed stream sample, ADC and generator side alike
  typedef logic signed [`RP_SAMPLE_W-1:0] sample_t;

  // gain, RP_UNITY_GAIN is 1.0
  typedef logic signed [`RP_GAIN_W-1:0] gain_t;

  // offset added after scaling, same range as a sample
  typedef logic signed [`RP_SAMPLE_W-1:0] offset_t;

  // offset binary code on the DAC pins
  typedef logic [`RP_SAMPLE_W-1:0] dac_code_t;

  // raw word on the ADC pins
  typedef logic [`RP_PIN_W-1:0] adc_pin_t;

  //////////////////////////////////////////////////////////////////////////
  // configuration port
  //////////////////////////////////////////////////////////////////////////

  // register map
  //   0     loopback enable, bit 0
  //   1, 2  ADC gain ch0, ch1
  //   3, 4  ADC offset ch0, ch1
  //   5, 6  DAC gain ch0, ch1
  //   7, 8  DAC offset ch0, ch1
  // unmapped addresses read as zero
  typedef logic [`RP_CFG_AW-1:0] cfg_addr_t;
  typedef logic [`RP_CFG_DW-1:0] cfg_data_t;

endpackage

/* verilog/cal_cfg_if.sv */
`include "rp_macros.svh"

interface cal_cfg_if;

  import rp_pkg::*;

  // feed calibrated DAC samples back into the ADC path
  logic dig_loop;

  // ADC calibration per channel
  gain_t   [`RP_CHN-1:0] adc_mul;
  offset_t [`RP_CHN-1:0] adc_sum;

  // DAC calibration per channel
  gain_t   [`RP_CHN-1:0] dac_mul;
  offset_t [`RP_CHN-1:0] dac_sum;

  // register bank owns every field
  modport regs (output dig_loop, adc_mul, adc_sum, dac_mul, dac_sum);

  // acquisition side
  modport adc (input dig_loop, adc_mul, adc_sum);

  // generation side
  modport dac (input dac_mul, dac_sum);

endinterface

/* verilog/cal_regs.sv */
`include "rp_macros.svh"

module cal_regs (
  input  logic              adc_clk,
  input  logic              top_rst,
  // write and read port
  input  logic              cfg_we_i,
  input  rp_pkg::cfg_addr_t cfg_addr_i,
  input  rp_pkg::cfg_data_t cfg_wdata_i,
  output rp_pkg::cfg_data_t cfg_rdata_o,
  // configuration out
  cal_cfg_if.regs           cfg
);

  import rp_pkg::*;

  // read mux ahead of the read-back register
  cfg_data_t rd_mux;

  ////////////////////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////////////////////

  // per-channel groups follow the loopback bit, one block of RP_CHN each
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cfg.dig_loop <= 1'b0;
      for (int i = 0; i < `RP_CHN; i++) begin
        cfg.adc_mul[i] <= gain_t'(`RP_UNITY_GAIN);
        cfg.adc_sum[i] <= '0;
        cfg.dac_mul[i] <= gain_t'(`RP_UNITY_GAIN);
        cfg.dac_sum[i] <= '0;
      end
    end else if (cfg_we_i) begin
      if (cfg_addr_i == cfg_addr_t'(0)) begin
        cfg.dig_loop <= cfg_wdata_i[0];
      end
      for (int i = 0; i < `RP_CHN; i++) begin
        if (cfg_addr_i == cfg_addr_t'(1 + i)) begin
          cfg.adc_mul[i] <= gain_t'(cfg_wdata_i);
        end
        // offsets keep the low sample bits only
        if (cfg_addr_i == cfg_addr_t'(1 + `RP_CHN + i)) begin
          cfg.adc_sum[i] <= offset_t'(cfg_wdata_i[`RP_SAMPLE_W-1:0]);
        end
        if (cfg_addr_i == cfg_addr_t'(1 + 2 * `RP_CHN + i)) begin
          cfg.dac_mul[i] <= gain_t'(cfg_wdata_i);
        end
        if (cfg_addr_i == cfg_addr_t'(1 + 3 * `RP_CHN + i)) begin
          cfg.dac_sum[i] <= offset_t'(cfg_wdata_i[`RP_SAMPLE_W-1:0]);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read-back
  ////////////////////////////////////////////////////////////////////////////

  // offsets come back sign extended
  always_comb begin
    rd_mux = '0;
    if (cfg_addr_i == cfg_addr_t'(0)) begin
      rd_mux = cfg_data_t'(cfg.dig_loop);
    end
    for (int i = 0; i < `RP_CHN; i++) begin
      if (cfg_addr_i == cfg_addr_t'(1 + i)) begin
        rd_mux = cfg_data_t'(cfg.adc_mul[i]);
      end
      if (cfg_addr_i == cfg_addr_t'(1 + `RP_CHN + i)) begin
        rd_mux = cfg_data_t'(cfg.adc_sum[i]);
      end
      if (cfg_addr_i == cfg_addr_t'(1 + 2 * `RP_CHN + i)) begin
        rd_mux = cfg_data_t'(cfg.dac_mul[i]);
      end
      if (cfg_addr_i == cfg_addr_t'(1 + 3 * `RP_CHN + i)) begin
        rd_mux = cfg_data_t'(cfg.dac_sum[i]);
      end
    end
  end

  // data for the address seen on the previous edge
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      cfg_rdata_o <= '0;
    end else begin
      cfg_rdata_o <= rd_mux;
    end
  end

  // host must stay inside the register map
  a_wr_in_map: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    cfg_we_i |-> (cfg_addr_i <= cfg_addr_t'(4 * `RP_CHN))
  );

endmodule

/* verilog/linear_cal.sv */
`include "rp_macros.svh"

module linear_cal (
  input  logic            adc_clk,
  input  logic            top_rst,
  // input stream
  input  rp_pkg::sample_t sti_dat_i,
  input  logic            sti_vld_i,
  output logic            sti_rdy_o,
  // output stream
  output rp_pkg::sample_t sto_dat_o,
  output logic            sto_vld_o,
  input  logic            sto_rdy_i,
  // calibration
  input  rp_pkg::gain_t   mul_i,
  input  rp_pkg::offset_t sum_i
);

  import rp_pkg::*;

  // full product, then what is left after dropping the gain fraction
  localparam int PRD_W = `RP_SAMPLE_W + `RP_GAIN_W;
  localparam int SCL_W = PRD_W - `RP_GAIN_FRAC;

  // clamp limits, one bit wider than the scaled value
  localparam logic signed [SCL_W:0] SAT_MAX = 2 ** (`RP_SAMPLE_W - 1) - 1;
  localparam logic signed [SCL_W:0] SAT_MIN = -(2 ** (`RP_SAMPLE_W - 1));

  logic                    pipe_en;
  logic signed [PRD_W-1:0] prd_q;
  logic                    prd_vld_q;
  logic signed [SCL_W-1:0] scl;
  logic signed [SCL_W:0]   acc;
  sample_t                 sat;

  // both stages move together, stall when the result is not taken
  assign pipe_en   = ~sto_vld_o | sto_rdy_i;
  assign sti_rdy_o = pipe_en;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, product
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      prd_vld_q <= 1'b0;
    end else if (pipe_en) begin
      prd_vld_q <= sti_vld_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (pipe_en) begin
      prd_q <= sti_dat_i * mul_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, shift, offset, saturate
  ////////////////////////////////////////////////////////////////////////////

  // arithmetic shift by the gain fraction
  assign scl = prd_q[PRD_W-1:`RP_GAIN_FRAC];
  assign acc = scl + sum_i;

  always_comb begin
    if (acc > SAT_MAX) begin
      sat = sample_t'(SAT_MAX);
    end else if (acc < SAT_MIN) begin
      sat = sample_t'(SAT_MIN);
    end else begin
      sat = sample_t'(acc);
    end
  end

  // result only moves on a real sample, so it holds the last one
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      sto_vld_o <= 1'b0;
      sto_dat_o <= '0;
    end else if (pipe_en) begin
      sto_vld_o <= prd_vld_q;
      if (prd_vld_q) begin
        sto_dat_o <= sat;
      end
    end
  end

  // no result offered before the unreset product stage has filled
  a_sto_known: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    sto_vld_o |-> !$isunknown(sto_dat_o)
  );

endmodule

/* verilog/adc_frontend.sv */
`include "rp_macros.svh"

module adc_frontend (
  input  logic                             adc_clk,
  input  logic                             top_rst,
  // ADC pins and loopback source
  input  rp_pkg::adc_pin_t [`RP_CHN-1:0]   adc_dat_i,
  input  rp_pkg::sample_t  [`RP_CHN-1:0]   loop_dat_i,
  // oscilloscope stream
  input  logic             [`RP_CHN-1:0]   osc_rdy_i,
  output rp_pkg::sample_t  [`RP_CHN-1:0]   osc_dat_o,
  output logic             [`RP_CHN-1:0]   osc_vld_o,
  // loopback enable and ADC calibration
  cal_cfg_if.adc                           cfg
);

  import rp_pkg::*;

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn

    // captured sample, ADC or loopback
    sample_t cap_q;

    // pins are inverted offset binary, low two bits unused
    // sign bit kept, rest inverted
    always_ff @(posedge adc_clk) begin
      if (cfg.dig_loop) begin
        cap_q <= loop_dat_i[i];
      end else begin
        cap_q <= {adc_dat_i[i][`RP_PIN_W-1],
                  ~adc_dat_i[i][`RP_PIN_W-2:`RP_PIN_W-`RP_SAMPLE_W]};
      end
    end

    // ADC never waits, samples offered while stalled are dropped
    linear_cal u_cal (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .sti_dat_i (cap_q),
      .sti_vld_i (1'b1),
      .sti_rdy_o (),
      .sto_dat_o (osc_dat_o[i]),
      .sto_vld_o (osc_vld_o[i]),
      .sto_rdy_i (osc_rdy_i[i]),
      .mul_i     (cfg.adc_mul[i]),
      .sum_i     (cfg.adc_sum[i])
    );

  end

endmodule

/* verilog/dac_backend.sv */
`include "rp_macros.svh"

module dac_backend (
  input  logic                              adc_clk,
  input  logic                              top_rst,
  // generator stream
  input  rp_pkg::sample_t   [`RP_CHN-1:0]   gen_dat_i,
  input  logic              [`RP_CHN-1:0]   gen_vld_i,
  output logic              [`RP_CHN-1:0]   gen_rdy_o,
  // DAC pins and loopback sample
  output rp_pkg::dac_code_t [`RP_CHN-1:0]   dac_dat_o,
  output rp_pkg::sample_t   [`RP_CHN-1:0]   loop_dat_o,
  // DAC calibration
  cal_cfg_if.dac                            cfg
);

  import rp_pkg::*;

  for (genvar i = 0; i < `RP_CHN; i++) begin : g_chn

    sample_t   cal_dat;
    logic      cal_vld;
    dac_code_t code_q;

    // DAC takes a sample every cycle, never back-pressured
    linear_cal u_cal (
      .adc_clk   (adc_clk),
      .top_rst   (top_rst),
      .sti_dat_i (gen_dat_i[i]),
      .sti_vld_i (gen_vld_i[i]),
      .sti_rdy_o (gen_rdy_o[i]),
      .sto_dat_o (cal_dat),
      .sto_vld_o (cal_vld),
      .sto_rdy_i (1'b1),
      .mul_i     (cfg.dac_mul[i]),
      .sum_i     (cfg.dac_sum[i])
    );

    // offset binary with negative slope, sign kept and magnitude inverted
    // holds the last code between samples
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        code_q <= dac_code_t'(`RP_DAC_RST_CODE);
      end else if (cal_vld) begin
        code_q <= {cal_dat[`RP_SAMPLE_W-1], ~cal_dat[`RP_SAMPLE_W-2:0]};
      end
    end

    assign dac_dat_o[i] = code_q;

    // calibrated sample straight from the stage register
    assign loop_dat_o[i] = cal_dat;

  end

endmodule

/* verilog/rp_analog_top.sv */
`include "rp_macros.svh"

module rp_analog_top (
  input  logic                              adc_clk,
  input  logic                              top_rst,
  // ADC pins
  input  rp_pkg::adc_pin_t  [`RP_CHN-1:0]   adc_dat_i,
  // generator stream in
  input  rp_pkg::sample_t   [`RP_CHN-1:0]   gen_dat_i,
  input  logic              [`RP_CHN-1:0]   gen_vld_i,
  output logic              [`RP_CHN-1:0]   gen_rdy_o,
  // oscilloscope stream out
  output rp_pkg::sample_t   [`RP_CHN-1:0]   osc_dat_o,
  output logic              [`RP_CHN-1:0]   osc_vld_o,
  input  logic              [`RP_CHN-1:0]   osc_rdy_i,
  // DAC codes, one per channel
  output rp_pkg::dac_code_t [`RP_CHN-1:0]   dac_dat_o,
  // configuration port
  input  logic                              cfg_we_i,
  input  rp_pkg::cfg_addr_t                 cfg_addr_i,
  input  rp_pkg::cfg_data_t                 cfg_wdata_i,
  output rp_pkg::cfg_data_t                 cfg_rdata_o
);

  import rp_pkg::*;

  // calibrated DAC samples for the digital loopback
  sample_t [`RP_CHN-1:0] loop_dat;

  // static calibration and loopback settings
  cal_cfg_if cfg ();

  ////////////////////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////////////////////

  cal_regs u_regs (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .cfg         (cfg.regs)
  );

  ////////////////////////////////////////////////////////////////////////////
  // ADC and DAC paths
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend u_adc (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .loop_dat_i (loop_dat),
    .osc_rdy_i  (osc_rdy_i),
    .osc_dat_o  (osc_dat_o),
    .osc_vld_o  (osc_vld_o),
    .cfg        (cfg.adc)
  );

  dac_backend u_dac (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .gen_dat_i  (gen_dat_i),
    .gen_vld_i  (gen_vld_i),
    .gen_rdy_o  (gen_rdy_o),
    .dac_dat_o  (dac_dat_o),
    .loop_dat_o (loop_dat),
    .cfg        (cfg.dac)
  );

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  // 40 unit period
  localparam int HALF_PERIOD = 20;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset held over the first two rising edges
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    #2;
    rst_o = 1'b0;
  end

endmodule

/* dv/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// compares made and compares failed
int chk_cnt = 0;
int err_cnt = 0;

task automatic check_sample(input string name, input rp_pkg::sample_t exp,
                            input rp_pkg::sample_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at time %0t: %s expected %0d got %0d", $time, name, exp, act);
  end
endtask

task automatic check_code(input string name, input rp_pkg::dac_code_t exp,
                          input rp_pkg::dac_code_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at time %0t: %s expected %0d got %0d", $time, name, exp, act);
  end
endtask

task automatic check_data(input string name, input rp_pkg::cfg_data_t exp,
                          input rp_pkg::cfg_data_t act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at time %0t: %s expected 0x%04h got 0x%04h", $time, name, exp, act);
  end
endtask

// valid and ready bits
task automatic check_flag(input string name, input logic exp, input logic act);
  chk_cnt++;
  if (act !== exp) begin
    err_cnt++;
    $display("CHECK FAILED at time %0t: %s expected %b got %b", $time, name, exp, act);
  end
endtask

`endif

/* dv/tb_top.sv */
`include "rp_macros.svh"

module tb_top;

  import rp_pkg::*;

  `include "tb_checks.svh"

  // register map, own copy
  localparam int REG_LOOP     = 0;
  localparam int REG_ADC_GAIN = 1;
  localparam int REG_ADC_OFF  = 3;
  localparam int REG_DAC_GAIN = 5;
  localparam int REG_DAC_OFF  = 7;

  // path latencies in cycles
  localparam int LAT_ADC  = 3;
  localparam int LAT_DAC  = 3;
  localparam int LAT_LOOP = 5;

  localparam int    CLK_PERIOD = 40;
  localparam gain_t UNITY      = `RP_UNITY_GAIN;
  // cycles per test, summed; watchdog allows 20 times that
  localparam int BUDGET = 60 + 30 + 70 + 50 + 60 + 30;

  logic                          adc_clk;
  logic                          top_rst;
  adc_pin_t  [`RP_CHN-1:0]       adc_dat;
  sample_t   [`RP_CHN-1:0]       gen_dat;
  logic      [`RP_CHN-1:0]       gen_vld;
  logic      [`RP_CHN-1:0]       gen_rdy;
  sample_t   [`RP_CHN-1:0]       osc_dat;
  logic      [`RP_CHN-1:0]       osc_vld;
  logic      [`RP_CHN-1:0]       osc_rdy;
  dac_code_t [`RP_CHN-1:0]       dac_dat;
  logic                          cfg_we;
  cfg_addr_t                     cfg_addr;
  cfg_data_t                     cfg_wdata;
  cfg_data_t                     cfg_rdata;

  // calibration as the DUT should hold it
  gain_t   adc_gain_m [`RP_CHN];
  offset_t adc_off_m  [`RP_CHN];
  gain_t   dac_gain_m [`RP_CHN];
  offset_t dac_off_m  [`RP_CHN];

  // expected results by drive cycle
  sample_t   exp_arr  [64][`RP_CHN];
  dac_code_t code_arr [64][`RP_CHN];

  tb_clk_gen u_clk (
    .clk_o (adc_clk),
    .rst_o (top_rst)
  );

  rp_analog_top uut (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat),
    .gen_dat_i   (gen_dat),
    .gen_vld_i   (gen_vld),
    .gen_rdy_o   (gen_rdy),
    .osc_dat_o   (osc_dat),
    .osc_vld_o   (osc_vld),
    .osc_rdy_i   (osc_rdy),
    .dac_dat_o   (dac_dat),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // pins 15..2 hold 8191 minus the sample, negative slope
  function automatic sample_t decode_pins(input adc_pin_t p);
    return sample_t'(8191 - int'(p >> (`RP_PIN_W - `RP_SAMPLE_W)));
  endfunction

  // pin word that decodes to s, unused low bits given
  function automatic adc_pin_t pins_for(input sample_t s, input logic [1:0] lo);
    logic [`RP_SAMPLE_W-1:0] top;
    top = 8191 - int'(s);
    return {top, lo};
  endfunction

  // scale, shift by the gain fraction, add offset, clamp
  function automatic sample_t calibrate(input sample_t x, input gain_t g, input offset_t o);
    int p;
    p = int'(x) * int'(g);
    p = p >>> `RP_GAIN_FRAC;
    p = p + int'(o);
    if (p > 8191) begin
      p = 8191;
    end else if (p < -8192) begin
      p = -8192;
    end
    return sample_t'(p);
  endfunction

  // offset binary, negative slope around mid-scale
  function automatic dac_code_t encode_dac(input sample_t s);
    return dac_code_t'(8191 - int'(s));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus helpers
  ////////////////////////////////////////////////////////////////////////////

  // inputs change just after the edge
  task automatic next_cycle();
    @(posedge adc_clk);
    #2;
  endtask

  task automatic write_reg(input int a, input cfg_data_t d);
    cfg_we    = 1'b1;
    cfg_addr  = cfg_addr_t'(a);
    cfg_wdata = d;
    next_cycle();
    cfg_we = 1'b0;
  endtask

  // read data lags the address by one edge
  task automatic read_expect(input int a, input cfg_data_t exp);
    cfg_addr = cfg_addr_t'(a);
    next_cycle();
    check_data($sformatf("cfg_rdata_o at address %0d", a), exp, cfg_rdata);
  endtask

  task automatic set_adc_cal(input int c, input gain_t g, input offset_t o);
    adc_gain_m[c] = g;
    adc_off_m[c]  = o;
    write_reg(REG_ADC_GAIN + c, cfg_data_t'(g));
    write_reg(REG_ADC_OFF + c, cfg_data_t'(o));
  endtask

  task automatic set_dac_cal(input int c, input gain_t g, input offset_t o);
    dac_gain_m[c] = g;
    dac_off_m[c]  = o;
    write_reg(REG_DAC_GAIN + c, cfg_data_t'(g));
    write_reg(REG_DAC_OFF + c, cfg_data_t'(o));
  endtask

  task automatic restore_cal();
    for (int c = 0; c < `RP_CHN; c++) begin
      set_adc_cal(c, UNITY, offset_t'(0));
      set_dac_cal(c, UNITY, offset_t'(0));
    end
  endtask

  // offsets read back sign extended
  task automatic read_all_cal();
    for (int c = 0; c < `RP_CHN; c++) begin
      read_expect(REG_ADC_GAIN + c, cfg_data_t'(adc_gain_m[c]));
      read_expect(REG_ADC_OFF + c, cfg_data_t'(adc_off_m[c]));
      read_expect(REG_DAC_GAIN + c, cfg_data_t'(dac_gain_m[c]));
      read_expect(REG_DAC_OFF + c, cfg_data_t'(dac_off_m[c]));
    end
  endtask

  // new pin word every cycle, result checked LAT_ADC cycles on
  task automatic adc_stream(input int n, input bit big);
    adc_pin_t pins;
    int       mag;
    for (int k = 0; k < n + LAT_ADC; k++) begin
      for (int c = 0; c < `RP_CHN; c++) begin
        if (k >= LAT_ADC) begin
          check_flag($sformatf("osc_vld_o[%0d]", c), 1'b1, osc_vld[c]);
          check_sample($sformatf("osc_dat_o[%0d]", c), exp_arr[k-LAT_ADC][c], osc_dat[c]);
        end
        if (k < n) begin
          if (big) begin
            // magnitude well past half scale
            mag  = 5000 + int'($urandom % 3192);
            pins = pins_for(sample_t'(($urandom % 2) ? mag : -mag), 2'($urandom));
          end else begin
            pins = adc_pin_t'($urandom);
          end
          adc_dat[c]    = pins;
          exp_arr[k][c] = calibrate(decode_pins(pins), adc_gain_m[c], adc_off_m[c]);
        end
      end
      next_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_readback();
    read_expect(REG_LOOP, 16'h0000);
    read_all_cal();
    // unmapped
    read_expect(9, 16'h0000);
    read_expect(15, 16'h0000);
    for (int c = 0; c < `RP_CHN; c++) begin
      check_code($sformatf("dac_dat_o[%0d]", c), dac_code_t'(`RP_DAC_RST_CODE), dac_dat[c]);
    end
    write_reg(REG_LOOP, 16'h0001);
    read_expect(REG_LOOP, 16'h0001);
    write_reg(REG_LOOP, 16'h0000);
    read_expect(REG_LOOP, 16'h0000);
    for (int c = 0; c < `RP_CHN; c++) begin
      set_adc_cal(c, gain_t'(12288 + c), offset_t'(-100 - c));
      set_dac_cal(c, gain_t'(-20000 + c), offset_t'(300 + c));
    end
    read_all_cal();
    restore_cal();
  endtask

  task automatic adc_decode_unity();
    adc_stream(20, 1'b0);
  endtask

  task automatic adc_gain_offset();
    set_adc_cal(0, gain_t'(12288), offset_t'(-100));
    // -1.0 flips the sign, -8192 clamps high
    set_adc_cal(1, gain_t'(-16384), offset_t'(50));
    adc_stream(16, 1'b0);
    // largest gain, just under 2.0
    set_adc_cal(0, gain_t'(32767), offset_t'(0));
    set_adc_cal(1, gain_t'(32767), offset_t'(300));
    adc_stream(16, 1'b1);
    restore_cal();
  endtask

  task automatic dac_encode_path();
    sample_t   s;
    dac_code_t hold [`RP_CHN];
    set_dac_cal(0, gain_t'(12288), offset_t'(200));
    set_dac_cal(1, gain_t'(-16384), offset_t'(-50));
    for (int k = 0; k < 24 + LAT_DAC; k++) begin
      for (int c = 0; c < `RP_CHN; c++) begin
        check_flag($sformatf("gen_rdy_o[%0d]", c), 1'b1, gen_rdy[c]);
        if (k >= LAT_DAC) begin
          check_code($sformatf("dac_dat_o[%0d]", c), code_arr[k-LAT_DAC][c], dac_dat[c]);
        end
        if (k < 24) begin
          // gaps in the stream, code must hold
          gen_vld[c] = (k == 0) || ($urandom % 4 != 0);
          s          = sample_t'($urandom);
          gen_dat[c] = s;
          if (gen_vld[c]) begin
            hold[c] = encode_dac(calibrate(s, dac_gain_m[c], dac_off_m[c]));
          end
          code_arr[k][c] = hold[c];
        end else begin
          gen_vld[c] = 1'b0;
        end
      end
      next_cycle();
    end
    restore_cal();
  endtask

  task automatic digital_loopback();
    sample_t s;
    write_reg(REG_LOOP, 16'h0001);
    set_dac_cal(0, gain_t'(8192), offset_t'(10));
    set_dac_cal(1, UNITY, offset_t'(-20));
    set_adc_cal(1, gain_t'(20480), offset_t'(5));
    for (int k = 0; k < 24 + LAT_LOOP; k++) begin
      for (int c = 0; c < `RP_CHN; c++) begin
        if (k >= LAT_LOOP) begin
          check_sample($sformatf("osc_dat_o[%0d]", c), exp_arr[k-LAT_LOOP][c], osc_dat[c]);
        end
        if (k < 24) begin
          s          = sample_t'($urandom);
          gen_vld[c] = 1'b1;
          gen_dat[c] = s;
          // DAC calibration first, then ADC calibration
          exp_arr[k][c] = calibrate(calibrate(s, dac_gain_m[c], dac_off_m[c]),
                                    adc_gain_m[c], adc_off_m[c]);
        end else begin
          gen_vld[c] = 1'b0;
        end
      end
      next_cycle();
    end
    write_reg(REG_LOOP, 16'h0000);
    restore_cal();
  endtask

  task automatic osc_backpressure();
    sample_t  held [`RP_CHN];
    adc_pin_t pins [`RP_CHN];
    for (int c = 0; c < `RP_CHN; c++) begin
      pins[c]    = adc_pin_t'($urandom);
      adc_dat[c] = pins[c];
    end
    repeat (LAT_ADC) next_cycle();
    // stall, output frozen on the decode of these pins
    for (int c = 0; c < `RP_CHN; c++) begin
      held[c] = calibrate(decode_pins(pins[c]), adc_gain_m[c], adc_off_m[c]);
    end
    osc_rdy = '0;
    repeat (8) begin
      for (int c = 0; c < `RP_CHN; c++) begin
        adc_dat[c] = adc_pin_t'($urandom);
      end
      next_cycle();
      for (int c = 0; c < `RP_CHN; c++) begin
        check_flag($sformatf("osc_vld_o[%0d]", c), 1'b1, osc_vld[c]);
        check_sample($sformatf("osc_dat_o[%0d]", c), held[c], osc_dat[c]);
      end
    end
    // release, fixed pins flush through
    for (int c = 0; c < `RP_CHN; c++) begin
      pins[c]    = adc_pin_t'($urandom);
      adc_dat[c] = pins[c];
    end
    osc_rdy = '1;
    repeat (LAT_ADC) next_cycle();
    for (int c = 0; c < `RP_CHN; c++) begin
      check_sample($sformatf("osc_dat_o[%0d]", c),
                   calibrate(decode_pins(pins[c]), adc_gain_m[c], adc_off_m[c]), osc_dat[c]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(66255));
    adc_dat   = '0;
    gen_dat   = '0;
    gen_vld   = '0;
    osc_rdy   = '1;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    for (int c = 0; c < `RP_CHN; c++) begin
      adc_gain_m[c] = UNITY;
      adc_off_m[c]  = '0;
      dac_gain_m[c] = UNITY;
      dac_off_m[c]  = '0;
    end
    @(negedge top_rst);
    next_cycle();
    reset_readback();
    adc_decode_unity();
    adc_gain_offset();
    dac_encode_path();
    digital_loopback();
    osc_backpressure();
    $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(20 * BUDGET * CLK_PERIOD);
    $display("watchdog: run went past %0d cycles without finishing", 20 * BUDGET);
    $display("test failed");
    $finish;
  end

endmodule

/* project.f */
+incdir+verilog
+incdir+dv
verilog/rp_pkg.sv
verilog/cal_cfg_if.sv
verilog/cal_regs.sv
verilog/linear_cal.sv
verilog/adc_frontend.sv
verilog/dac_backend.sv
verilog/rp_analog_top.sv
dv/tb_clk_gen.sv
dv/tb_top.sv
